// File: rtl/conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// kernel edge, the window is CONV_K columns of CONV_K rows.
`define CONV_K 5
`define CONV_TAPS 25

// pixels and coefficients share one width.
`define CONV_PIX_W 6

// 25 * 63 * 63 = 99225 fits in 18 bits.
`define CONV_SUM_W 18

`endif

// File: rtl/conv_pkg.sv
`include "conv_defs.svh"

package conv_pkg;

  typedef logic [`CONV_PIX_W-1:0] pixel_t;
  typedef logic [`CONV_PIX_W-1:0] coef_t;

  // full 6x6 product, no truncation.
  typedef logic [2*`CONV_PIX_W-1:0] product_t;

  typedef logic [`CONV_SUM_W-1:0] sum_t;

  // row 0 in the low field.
  typedef logic [`CONV_K*`CONV_PIX_W-1:0] column_t;

  // row * 5 + col.
  typedef logic [$clog2(`CONV_TAPS)-1:0] tap_idx_t;

endpackage

// File: rtl/kernel_regs.sv
`timescale 1ns/1ns
`include "conv_defs.svh"

module kernel_regs (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               kernel_we,
  input  conv_pkg::tap_idx_t                 kernel_idx,
  input  conv_pkg::coef_t                    kernel_val,
  output logic [`CONV_TAPS*`CONV_PIX_W-1:0]  kernel_flat
);

  import conv_pkg::*;

  coef_t coef_q [0:`CONV_TAPS-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CONV_TAPS; i++) begin
        coef_q[i] <= '0;
      end
    end else if (kernel_we && (kernel_idx < `CONV_TAPS)) begin
      coef_q[kernel_idx] <= kernel_val; // indices 25..31 are dropped.
    end
  end

  // tap i goes to field i of the flat bus.
  always_comb begin
    for (int i = 0; i < `CONV_TAPS; i++) begin
      kernel_flat[i*`CONV_PIX_W +: `CONV_PIX_W] = coef_q[i];
    end
  end

endmodule

// File: rtl/window_shift.sv
`timescale 1ns/1ns
`include "conv_defs.svh"

module window_shift (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               restart,
  input  logic                               col_valid,
  input  conv_pkg::column_t                  col_pix,
  output logic                               win_valid,
  output logic [`CONV_TAPS*`CONV_PIX_W-1:0]  win_flat
);

  import conv_pkg::*;

  column_t    col_q [0:`CONV_K-1]; // column 0 is the oldest.
  logic [2:0] fill_cnt;
  logic [2:0] base_cnt;
  logic [2:0] next_cnt;

  // restart takes effect before a column in the same cycle.
  always_comb begin
    base_cnt = restart ? 3'd0 : fill_cnt;
    if (base_cnt == 3'(`CONV_K)) begin
      next_cnt = base_cnt; // saturate.
    end else begin
      next_cnt = base_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_cnt  <= '0;
      win_valid <= 1'b0;
    end else begin
      fill_cnt  <= col_valid ? next_cnt : base_cnt;
      win_valid <= col_valid && (next_cnt == 3'(`CONV_K));
    end
  end

  always_ff @(posedge clk) begin
    if (col_valid) begin
      for (int c = 0; c < `CONV_K-1; c++) begin
        col_q[c] <= col_q[c+1];
      end
      col_q[`CONV_K-1] <= col_pix;
    end
  end

  // transpose columns into the row-major tap order.
  always_comb begin
    for (int r = 0; r < `CONV_K; r++) begin
      for (int c = 0; c < `CONV_K; c++) begin
        win_flat[(r*`CONV_K+c)*`CONV_PIX_W +: `CONV_PIX_W] =
          col_q[c][r*`CONV_PIX_W +: `CONV_PIX_W];
      end
    end
  end

endmodule

// File: rtl/product_stage.sv
`timescale 1ns/1ns
`include "conv_defs.svh"

module product_stage (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 win_valid,
  input  logic [`CONV_TAPS*`CONV_PIX_W-1:0]    win_flat,
  input  logic [`CONV_TAPS*`CONV_PIX_W-1:0]    kernel_flat,
  output logic                                 prod_valid,
  output logic [`CONV_TAPS*2*`CONV_PIX_W-1:0]  prod_flat
);

  import conv_pkg::*;

  localparam int PROD_W = 2*`CONV_PIX_W;

  product_t prod_d [0:`CONV_TAPS-1];

  // add the pixel, shifted by each set coefficient bit.
  function automatic product_t shift_add(pixel_t a, coef_t b);
    product_t acc;
    acc = '0;
    for (int i = 0; i < `CONV_PIX_W; i++) begin
      if (b[i]) begin
        acc = acc + (product_t'(a) << i);
      end
    end
    return acc;
  endfunction

  always_comb begin
    for (int t = 0; t < `CONV_TAPS; t++) begin
      prod_d[t] = shift_add(win_flat[t*`CONV_PIX_W +: `CONV_PIX_W],
                            kernel_flat[t*`CONV_PIX_W +: `CONV_PIX_W]);
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid) begin
      for (int t = 0; t < `CONV_TAPS; t++) begin
        prod_flat[t*PROD_W +: PROD_W] <= prod_d[t];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= win_valid;
    end
  end

endmodule

// File: rtl/adder_tree.sv
`timescale 1ns/1ns
`include "conv_defs.svh"

module adder_tree (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 prod_valid,
  input  logic [`CONV_TAPS*2*`CONV_PIX_W-1:0]  prod_flat,
  output logic                                 out_valid,
  output conv_pkg::sum_t                       out_data
);

  import conv_pkg::*;

  localparam int PROD_W = 2*`CONV_PIX_W;

  sum_t     part_d [0:`CONV_K-1];
  sum_t     part_q [0:`CONV_K-1]; // one partial per kernel row.
  sum_t     total_d;
  product_t prod_t;
  logic     part_valid;

  // first level, five products per row.
  always_comb begin
    for (int g = 0; g < `CONV_K; g++) begin
      part_d[g] = '0;
      for (int j = 0; j < `CONV_K; j++) begin
        prod_t    = prod_flat[(g*`CONV_K+j)*PROD_W +: PROD_W];
        part_d[g] = part_d[g] + sum_t'(prod_t);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      for (int g = 0; g < `CONV_K; g++) begin
        part_q[g] <= part_d[g];
      end
    end
  end

  // second level.
  always_comb begin
    total_d = '0;
    for (int g = 0; g < `CONV_K; g++) begin
      total_d = total_d + part_q[g];
    end
  end

  always_ff @(posedge clk) begin
    if (part_valid) begin
      out_data <= total_d;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      part_valid <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      part_valid <= prod_valid;
      out_valid  <= part_valid;
    end
  end

endmodule

// File: rtl/conv5x5_top.sv
`timescale 1ns/1ns
`include "conv_defs.svh"

module conv5x5_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                kernel_we,
  input  conv_pkg::tap_idx_t  kernel_idx,
  input  conv_pkg::coef_t     kernel_val,
  input  logic                restart,
  input  logic                col_valid,
  input  conv_pkg::column_t   col_pix,
  output logic                out_valid,
  output conv_pkg::sum_t      out_data
);

  logic [`CONV_TAPS*`CONV_PIX_W-1:0]   kernel_flat;
  logic [`CONV_TAPS*`CONV_PIX_W-1:0]   win_flat;
  logic                                win_valid;
  logic [`CONV_TAPS*2*`CONV_PIX_W-1:0] prod_flat;
  logic                                prod_valid;

  kernel_regs u_kernel_regs (
    .clk         (clk),
    .reset       (reset),
    .kernel_we   (kernel_we),
    .kernel_idx  (kernel_idx),
    .kernel_val  (kernel_val),
    .kernel_flat (kernel_flat)
  );

  // window register, then product, then two adder levels.
  window_shift u_window_shift (
    .clk       (clk),
    .reset     (reset),
    .restart   (restart),
    .col_valid (col_valid),
    .col_pix   (col_pix),
    .win_valid (win_valid),
    .win_flat  (win_flat)
  );

  product_stage u_product_stage (
    .clk         (clk),
    .reset       (reset),
    .win_valid   (win_valid),
    .win_flat    (win_flat),
    .kernel_flat (kernel_flat),
    .prod_valid  (prod_valid),
    .prod_flat   (prod_flat)
  );

  adder_tree u_adder_tree (
    .clk        (clk),
    .reset      (reset),
    .prod_valid (prod_valid),
    .prod_flat  (prod_flat),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

endmodule

// File: verif/conv5x5_props.sv
`timescale 1ns/1ns

module conv5x5_props (
  input logic           clk,
  input logic           reset,
  input logic           col_valid,
  input logic           out_valid,
  input conv_pkg::sum_t out_data
);

  // nothing comes out in the first cycle after reset.
  quiet_after_reset: assert property (
    @(posedge clk) reset |=> !out_valid
  ) else $error("out_valid high in the cycle after reset");

  // window, product and two adder levels.
  result_latency: assert property (
    @(posedge clk) disable iff (reset)
    out_valid |-> $past(col_valid, 4)
  ) else $error("out_valid without a column four cycles earlier");

  // 25 * 63 * 63.
  result_range: assert property (
    @(posedge clk) disable iff (reset)
    out_valid |-> (out_data <= 18'd99225)
  ) else $error("out_data above the largest possible sum");

endmodule

// File: verif/conv5x5_tb.sv
`timescale 1ns/1ns
`include "conv_defs.svh"

module conv5x5_tb;

  import conv_pkg::*;

  logic     clk;
  logic     reset;
  logic     kernel_we;
  tap_idx_t kernel_idx;
  coef_t    kernel_val;
  logic     restart;
  logic     col_valid;
  column_t  col_pix;
  logic     out_valid;
  sum_t     out_data;

  logic [31:0] rng_state = 32'h799c;
  int          errors;
  int          results_seen;
  int          last_result;
  int          exp_sum;
  int          model_kernel [0:`CONV_TAPS-1];
  int          hist [0:`CONV_K-1][0:`CONV_K-1]; // [col][row], col 0 oldest.
  int          model_fill;
  int          expected_q [$];
  int          start;

  conv5x5_top UUT (
    .clk        (clk),
    .reset      (reset),
    .kernel_we  (kernel_we),
    .kernel_idx (kernel_idx),
    .kernel_val (kernel_val),
    .restart    (restart),
    .col_valid  (col_valid),
    .col_pix    (col_pix),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

  bind conv5x5_top conv5x5_props u_props (
    .clk       (clk),
    .reset     (reset),
    .col_valid (col_valid),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // sum over the window, tap index is row * 5 + col.
  function automatic int model_sum();
    int acc;
    acc = 0;
    for (int r = 0; r < `CONV_K; r++) begin
      for (int c = 0; c < `CONV_K; c++) begin
        acc += hist[c][r] * model_kernel[r*`CONV_K+c];
      end
    end
    return acc;
  endfunction

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_coef(input int idx, input int val);
    kernel_we  = 1'b1;
    kernel_idx = tap_idx_t'(idx);
    kernel_val = coef_t'(val);
    if (idx < `CONV_TAPS) model_kernel[idx] = val; // out of range is dropped.
    idle_cycles(1);
    kernel_we = 1'b0;
  endtask

  task automatic load_kernel(input int fixed_val, input logic random_vals);
    for (int i = 0; i < `CONV_TAPS; i++) begin
      write_coef(i, random_vals ? int'(next_rand() % 64) : fixed_val);
    end
  endtask

  task automatic send_column(input column_t pix, input logic with_restart);
    col_valid = 1'b1;
    col_pix   = pix;
    restart   = with_restart;
    if (with_restart) model_fill = 0;
    for (int c = 0; c < `CONV_K-1; c++) begin
      for (int r = 0; r < `CONV_K; r++) begin
        hist[c][r] = hist[c+1][r];
      end
    end
    for (int r = 0; r < `CONV_K; r++) begin
      hist[`CONV_K-1][r] = int'(pix[r*`CONV_PIX_W +: `CONV_PIX_W]);
    end
    if (model_fill < `CONV_K) model_fill++;
    if (model_fill == `CONV_K) expected_q.push_back(model_sum());
    idle_cycles(1);
    col_valid = 1'b0;
    restart   = 1'b0;
  endtask

  // first column restarts the window.
  task automatic send_stream(input int n, input int max_gap);
    for (int i = 0; i < n; i++) begin
      send_column(column_t'(next_rand()), i == 0);
      if (max_gap > 0) idle_cycles(int'(next_rand() % (max_gap + 1)));
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < 40) begin
      idle_cycles(1);
      cycles++;
    end
    if (expected_q.size() != 0) begin
      errors++;
      $display("timeout, %0d expected results never came out", expected_q.size());
    end
    idle_cycles(6); // room for a stray late result.
  endtask

  task automatic check_count(input int from, input int n);
    assert (results_seen - from == n) else begin
      errors++;
      $display("wrong number of results, expected %0d but saw %0d", n, results_seen - from);
    end
  endtask

  always @(negedge clk) begin
    if (!reset && out_valid) begin
      results_seen++;
      last_result = int'(out_data);
      if (expected_q.size() == 0) begin
        errors++;
        $display("result came out with no column waiting for it at %0t", $time);
      end else begin
        exp_sum = expected_q.pop_front();
        assert (int'(out_data) == exp_sum) else begin
          errors++;
          $display("ERROR out_data expected %h actual %h", exp_sum, out_data);
        end
      end
    end
  end

  initial begin
    reset = 1'b1;
    kernel_we = 1'b0;
    kernel_idx = '0;
    kernel_val = '0;
    restart = 1'b0;
    col_valid = 1'b0;
    col_pix = '0;
    errors = 0;
    results_seen = 0;
    last_result = 0;
    model_fill = 0;
    foreach (model_kernel[i]) model_kernel[i] = 0;
    foreach (hist[c, r]) hist[c][r] = 0;
    idle_cycles(4);
    reset = 1'b0;
    idle_cycles(2);

    load_kernel(0, 1'b1);
    start = results_seen;
    send_stream(5, 0);
    wait_drained();
    check_count(start, 1);

    start = results_seen;
    send_stream(200, 0);
    wait_drained();
    check_count(start, 196);

    start = results_seen;
    send_stream(60, 3);
    wait_drained();
    check_count(start, 56);

    // restart mid-stream, the next four columns must stay silent.
    start = results_seen;
    send_stream(8, 0);
    restart = 1'b1;
    model_fill = 0;
    idle_cycles(1);
    restart = 1'b0;
    for (int i = 0; i < 4; i++) send_column(column_t'(next_rand()), 1'b0);
    wait_drained();
    check_count(start, 4);
    send_column(column_t'(next_rand()), 1'b0);
    wait_drained();
    check_count(start, 5);

    load_kernel(63, 1'b0);
    for (int i = 0; i < 5; i++) send_column({5{6'd63}}, i == 0);
    wait_drained();
    assert (last_result == 99225) else begin
      errors++;
      $display("ERROR out_data expected %h actual %h", 99225, last_result);
    end
    load_kernel(0, 1'b0);
    send_stream(5, 0);
    wait_drained();
    assert (last_result == 0) else begin
      errors++;
      $display("ERROR out_data expected %h actual %h", 0, last_result);
    end

    load_kernel(0, 1'b1);
    write_coef(27, 63);
    write_coef(31, 17);
    start = results_seen;
    send_stream(20, 1);
    wait_drained();
    check_count(start, 16);

    $display("errors: %0d, results checked: %0d", errors, results_seen);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: conv5x5_top.f
+incdir+rtl
rtl/conv_pkg.sv
rtl/kernel_regs.sv
rtl/window_shift.sv
rtl/product_stage.sv
rtl/adder_tree.sv
rtl/conv5x5_top.sv
verif/conv5x5_props.sv
verif/conv5x5_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= conv5x5_tb
FILELIST  ?= conv5x5_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)
